// File: design/dsi_timing_pkg.sv
// Raster timing for the DSI video source.
// Horizontal periods are in byte clocks, vertical periods in lines.
// Timers and sequencer refer to these by scoped names.

package dsi_timing_pkg;

    ////////////////////////////////////////////////////
    // position types
    ////////////////////////////////////////////////////

    typedef logic [15:0] col_t;
    typedef logic [11:0] line_t;

    // step marks the column as consumed in this cycle
    typedef struct packed {
        logic step;
        col_t col;
    } h_pos_t;

    typedef enum logic [1:0] {
        v_sync,
        v_back,
        v_active,
        v_front
    } v_region_e;

    ////////////////////////////////////////////////////
    // horizontal raster
    ////////////////////////////////////////////////////

    localparam col_t HSA         = 16'd4;
    localparam col_t HBP         = 16'd6;
    localparam col_t HACT        = 16'd24;
    localparam col_t HFP         = 16'd6;
    localparam col_t H_TOTAL     = HSA + HBP + HACT + HFP;
    // first and last payload column
    localparam col_t H_ACT_START = HSA + HBP;
    localparam col_t H_ACT_LAST  = HSA + HBP + HACT - 16'd1;

    // vertical raster, in lines
    localparam line_t VSA         = 12'd2;
    localparam line_t VBP         = 12'd2;
    localparam line_t VACT        = 12'd4;
    localparam line_t VFP         = 12'd2;
    localparam line_t V_TOTAL     = VSA + VBP + VACT + VFP;
    localparam line_t V_ACT_START = VSA + VBP;
    localparam line_t V_ACT_LAST  = VSA + VBP + VACT - 12'd1;

endpackage

// File: design/dsi_pkt_pkg.sv
// DSI packet definitions for the video source.
// Holds data type codes, the header struct on the packet port
// and the seed of the payload byte generator.

package dsi_pkt_pkg;

    typedef logic [5:0]  data_type_t;
    typedef logic [15:0] word_count_t;
    typedef logic [7:0]  byte_t;

    // header seen on the packet port, sp and lp never together
    typedef struct packed {
        logic        sp;
        logic        lp;
        data_type_t  dt;
        word_count_t wc;
    } pkt_hdr_t;

    ////////////////////////////////////////////////////
    // data type codes
    ////////////////////////////////////////////////////

    localparam data_type_t DT_VSYNC_START = 6'h01;
    localparam data_type_t DT_VSYNC_END   = 6'h11;
    localparam data_type_t DT_HSYNC_START = 6'h21;
    localparam data_type_t DT_HSYNC_END   = 6'h31;
    localparam data_type_t DT_RGB888      = 6'h3E;

    // rgb888 over three byte lanes
    localparam int BYTES_PER_PIXEL = 3;
    localparam int LANE_BYTES      = 3;

    // equals HACT, kept named for the long-packet header
    localparam word_count_t ACTIVE_WC =
        word_count_t'(dsi_timing_pkg::HACT * BYTES_PER_PIXEL / LANE_BYTES);

    // nothing on the port
    localparam pkt_hdr_t PKT_IDLE = '0;

    localparam logic [15:0] PRBS_SEED = 16'hACE1;

endpackage

// File: design/line_timer.sv
// Horizontal timer of the DSI video source.
// Walks the columns of one line, one per enabled clock, and
// reports the current column with a step flag and the line end.

`timescale 1ns/10ps

module line_timer (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  enable_i,
    output dsi_timing_pkg::h_pos_t h_pos_o,
    output logic                  line_end_o
);

    typedef enum logic [1:0] {
        h_sync,
        h_back,
        h_active,
        h_front
    } h_region_e;

    h_region_e            region_q;
    dsi_timing_pkg::col_t col_q;
    logic                 region_last;

    // last column of the region we are in
    always_comb begin
        case (region_q)
            h_sync:   region_last = (col_q == dsi_timing_pkg::HSA - 16'd1);
            h_back:   region_last = (col_q == dsi_timing_pkg::H_ACT_START - 16'd1);
            h_active: region_last = (col_q == dsi_timing_pkg::H_ACT_LAST);
            default:  region_last = (col_q == dsi_timing_pkg::H_TOTAL - 16'd1);
        endcase
    end

    ////////////////////////////////////////////////////
    // column counter and region state machine
    ////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            col_q    <= '0;
            region_q <= h_sync;
        end else if (enable_i) begin
            if (region_last) begin
                case (region_q)
                    h_sync:   region_q <= h_back;
                    h_back:   region_q <= h_active;
                    h_active: region_q <= h_front;
                    default:  region_q <= h_sync;
                endcase
            end
            // wrap back to column 0 after the front porch
            if (region_last && region_q == h_front) begin
                col_q <= '0;
            end else begin
                col_q <= col_q + 16'd1;
            end
        end
    end

    // the column is consumed only on an enabled clock
    assign h_pos_o = '{step: enable_i, col: col_q};

    assign line_end_o = enable_i & region_last & (region_q == h_front);

endmodule

// File: design/frame_timer.sv
// Vertical timer of the DSI video source.
// Counts lines on each line end from the line timer and
// tracks which vertical region the raster is in.

`timescale 1ns/10ps

module frame_timer (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      line_end_i,
    output dsi_timing_pkg::line_t     line_o,
    output dsi_timing_pkg::v_region_e v_region_o
);

    dsi_timing_pkg::line_t     line_q;
    dsi_timing_pkg::v_region_e region_q;
    logic                      region_last;

    // last line of the current region
    always_comb begin
        case (region_q)
            dsi_timing_pkg::v_sync:
                region_last = (line_q == dsi_timing_pkg::VSA - 12'd1);
            dsi_timing_pkg::v_back:
                region_last = (line_q == dsi_timing_pkg::V_ACT_START - 12'd1);
            dsi_timing_pkg::v_active:
                region_last = (line_q == dsi_timing_pkg::V_ACT_LAST);
            default:
                region_last = (line_q == dsi_timing_pkg::V_TOTAL - 12'd1);
        endcase
    end

    ////////////////////////////////////////////////////
    // line counter and vertical state machine
    ////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            line_q   <= '0;
            region_q <= dsi_timing_pkg::v_sync;
        end else if (line_end_i) begin
            if (region_last) begin
                case (region_q)
                    dsi_timing_pkg::v_sync:   region_q <= dsi_timing_pkg::v_back;
                    dsi_timing_pkg::v_back:   region_q <= dsi_timing_pkg::v_active;
                    dsi_timing_pkg::v_active: region_q <= dsi_timing_pkg::v_front;
                    default:                  region_q <= dsi_timing_pkg::v_sync;
                endcase
            end
            // frame wraps after the front porch
            if (region_last && region_q == dsi_timing_pkg::v_front) begin
                line_q <= '0;
            end else begin
                line_q <= line_q + 12'd1;
            end
        end
    end

    assign line_o     = line_q;
    assign v_region_o = region_q;

endmodule

// File: design/packet_sequencer.sv
// Packet sequencer of the DSI video source.
// Turns the stepped raster position into sync short packets,
// the rgb888 long-packet header and the payload window.
// All outputs are registered, one clock after the position.

`timescale 1ns/10ps

module packet_sequencer (
    input  logic                      clk,
    input  logic                      reset,
    input  dsi_timing_pkg::h_pos_t    h_pos_i,
    input  dsi_timing_pkg::line_t     line_i,
    input  dsi_timing_pkg::v_region_e v_region_i,
    output dsi_pkt_pkg::pkt_hdr_t     pkt_o,
    output logic                      payload_en_o,
    output logic                      frame_start_o
);

    dsi_pkt_pkg::pkt_hdr_t pkt_d;
    logic                  payload_en_d;
    logic                  frame_start_d;

    logic vs_start_line;
    logic vs_end_line;
    logic active_line;
    logic in_payload;

    assign vs_start_line = (line_i == '0);
    assign vs_end_line   = (line_i == dsi_timing_pkg::VSA);
    assign active_line   = (v_region_i == dsi_timing_pkg::v_active);

    assign in_payload = (h_pos_i.col >= dsi_timing_pkg::H_ACT_START) &&
                        (h_pos_i.col <= dsi_timing_pkg::H_ACT_LAST);

    ////////////////////////////////////////////////////
    // position decode
    ////////////////////////////////////////////////////

    always_comb begin
        pkt_d         = dsi_pkt_pkg::PKT_IDLE;
        payload_en_d  = 1'b0;
        frame_start_d = 1'b0;

        if (h_pos_i.step) begin
            if (h_pos_i.col == '0) begin
                // every line opens with a sync short packet, wc stays 0
                pkt_d.sp = 1'b1;
                if (vs_start_line) begin
                    pkt_d.dt      = dsi_pkt_pkg::DT_VSYNC_START;
                    frame_start_d = 1'b1;
                end else if (vs_end_line) begin
                    pkt_d.dt = dsi_pkt_pkg::DT_VSYNC_END;
                end else begin
                    pkt_d.dt = dsi_pkt_pkg::DT_HSYNC_START;
                end
            end else if (h_pos_i.col == dsi_timing_pkg::HSA) begin
                // hsync end only closes an hsync start
                if (!vs_start_line && !vs_end_line) begin
                    pkt_d.sp = 1'b1;
                    pkt_d.dt = dsi_pkt_pkg::DT_HSYNC_END;
                end
            end else if (active_line &&
                         h_pos_i.col == dsi_timing_pkg::H_ACT_START - 16'd1) begin
                // header one column ahead of the payload
                pkt_d.lp = 1'b1;
                pkt_d.dt = dsi_pkt_pkg::DT_RGB888;
                pkt_d.wc = dsi_pkt_pkg::ACTIVE_WC;
            end else if (active_line && in_payload) begin
                payload_en_d = 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////
    // output registers
    ////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pkt_o         <= dsi_pkt_pkg::PKT_IDLE;
            payload_en_o  <= 1'b0;
            frame_start_o <= 1'b0;
        end else begin
            pkt_o         <= pkt_d;
            payload_en_o  <= payload_en_d;
            frame_start_o <= frame_start_d;
        end
    end

endmodule

// File: design/payload_prbs.sv
// Payload byte source for the long packets.
// A 16-bit Fibonacci LFSR, reseeded once per frame, whose
// low byte is presented while the payload window is open.

`timescale 1ns/10ps

module payload_prbs (
    input  logic               clk,
    input  logic               reset,
    input  logic               reseed_i,
    input  logic               advance_i,
    output dsi_pkt_pkg::byte_t byte_o
);

    logic [15:0] lfsr_q;
    logic        feedback;

    // taps 16, 14, 13 and 11
    assign feedback = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lfsr_q <= dsi_pkt_pkg::PRBS_SEED;
        end else if (reseed_i) begin
            lfsr_q <= dsi_pkt_pkg::PRBS_SEED;
        end else if (advance_i) begin
            // shift left, feedback enters bit 0
            lfsr_q <= {lfsr_q[14:0], feedback};
        end
    end

    // zero outside the payload window
    assign byte_o = advance_i ? lfsr_q[7:0] : '0;

endmodule

// File: design/dsi_video_source.sv
// Top level of the DSI video-mode source.
// enable_i high consumes one raster position per clock; packet
// headers and payload bytes follow one clock later.

`timescale 1ns/10ps

module dsi_video_source (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  enable_i,
    output dsi_pkt_pkg::pkt_hdr_t pkt_o,
    output logic                  payload_en_o,
    output dsi_pkt_pkg::byte_t    byte_data_o
);

    dsi_timing_pkg::h_pos_t    h_pos;
    dsi_timing_pkg::line_t     line;
    dsi_timing_pkg::v_region_e v_region;
    logic                      line_end;
    logic                      frame_start;

    line_timer u_line_timer (
        .clk        (clk),
        .reset      (reset),
        .enable_i   (enable_i),
        .h_pos_o    (h_pos),
        .line_end_o (line_end)
    );

    frame_timer u_frame_timer (
        .clk        (clk),
        .reset      (reset),
        .line_end_i (line_end),
        .line_o     (line),
        .v_region_o (v_region)
    );

    packet_sequencer u_packet_sequencer (
        .clk           (clk),
        .reset         (reset),
        .h_pos_i       (h_pos),
        .line_i        (line),
        .v_region_i    (v_region),
        .pkt_o         (pkt_o),
        .payload_en_o  (payload_en_o),
        .frame_start_o (frame_start)
    );

    // reseed at vsync start, step through the payload window
    payload_prbs u_payload_prbs (
        .clk       (clk),
        .reset     (reset),
        .reseed_i  (frame_start),
        .advance_i (payload_en_o),
        .byte_o    (byte_data_o)
    );

endmodule

// File: sim/dsi_video_props.sv
// Concurrent assertions on the packet port of the sequencer.
// Bound to packet_sequencer from the testbench top.

`timescale 1ns/10ps

module dsi_video_props (
    input logic                  clk,
    input logic                  reset,
    input dsi_pkt_pkg::pkt_hdr_t pkt_i,
    input logic                  payload_en_i,
    input logic                  frame_start_i
);

    // number of failed assertions
    int assert_errors;

    sp_lp_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(pkt_i.sp && pkt_i.lp))
        else begin
            $error("short and long packet flags high together");
            assert_errors = assert_errors + 1;
        end

    dt_needs_packet: assert property (@(posedge clk) disable iff (reset)
        (pkt_i.dt != '0) |-> (pkt_i.sp || pkt_i.lp))
        else begin
            $error("data type set with no packet flag");
            assert_errors = assert_errors + 1;
        end

    // short packets here always carry a zero word count
    wc_needs_long: assert property (@(posedge clk) disable iff (reset)
        (pkt_i.wc != '0) |-> pkt_i.lp)
        else begin
            $error("word count set outside a long-packet header");
            assert_errors = assert_errors + 1;
        end

    payload_outside_hdr: assert property (@(posedge clk) disable iff (reset)
        payload_en_i |-> !(pkt_i.sp || pkt_i.lp))
        else begin
            $error("payload window overlaps a packet header");
            assert_errors = assert_errors + 1;
        end

    frame_start_on_vsync: assert property (@(posedge clk) disable iff (reset)
        frame_start_i |-> (pkt_i.sp && pkt_i.dt == dsi_pkt_pkg::DT_VSYNC_START))
        else begin
            $error("frame start without vsync start");
            assert_errors = assert_errors + 1;
        end

endmodule

// File: sim/dsi_video_checker.sv
// Reference model and scoreboard for the DSI video source.
// Follows the raster position and the payload LFSR from enable_i
// and compares every DUT output on each rising clock edge.

`timescale 1ns/10ps

module dsi_video_checker (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  enable_i,
    input  dsi_pkt_pkg::pkt_hdr_t pkt_i,
    input  logic                  payload_en_i,
    input  dsi_pkt_pkg::byte_t    byte_data_i,
    output int                    frames_o,
    output int                    checks_o,
    output int                    pkt_errors_o,
    output int                    payload_errors_o,
    output int                    byte_errors_o
);

    // model position, and what the DUT must show after the next edge
    dsi_timing_pkg::col_t  col;
    dsi_timing_pkg::line_t line;
    dsi_timing_pkg::col_t  exp_col;
    dsi_timing_pkg::line_t exp_line;
    logic                  exp_step;
    dsi_pkt_pkg::pkt_hdr_t exp_pkt;
    logic                  exp_pen;
    logic                  exp_frame_start;
    logic [15:0]           lfsr;

    // payload clocks seen since the last long-packet header
    int   pen_run;
    logic header_seen;

    int frames;
    int checks;
    int pkt_errors;
    int payload_errors;
    int byte_errors;

    assign frames_o         = frames;
    assign checks_o         = checks;
    assign pkt_errors_o     = pkt_errors;
    assign payload_errors_o = payload_errors;
    assign byte_errors_o    = byte_errors;

    function automatic bit field_ok(input string name, input logic [31:0] expected,
                                    input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s expected %0h actual %0h at %0t", name, expected, actual,
                     $time);
            return 1'b0;
        end
        return 1'b1;
    endfunction

    // taps 16, 14, 13 and 11 counted from 1, new bit enters at the bottom
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic fb;
        fb = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], fb};
    endfunction

    //////////////////////////////////////////////////
    // comparison
    //////////////////////////////////////////////////

    task automatic compare_outputs();
        string              where;
        dsi_pkt_pkg::byte_t exp_byte;
        if (exp_step) begin
            where = $sformatf("line %0d col %0d", exp_line, exp_col);
        end else begin
            where = "after disabled clock";
        end
        exp_byte = exp_pen ? lfsr[7:0] : 8'h00;
        if (!field_ok({"pkt_sp ", where}, 32'(exp_pkt.sp), 32'(pkt_i.sp))) pkt_errors++;
        if (!field_ok({"pkt_lp ", where}, 32'(exp_pkt.lp), 32'(pkt_i.lp))) pkt_errors++;
        if (!field_ok({"pkt_dt ", where}, 32'(exp_pkt.dt), 32'(pkt_i.dt))) pkt_errors++;
        if (!field_ok({"pkt_wc ", where}, 32'(exp_pkt.wc), 32'(pkt_i.wc))) pkt_errors++;
        if (!field_ok({"payload_en ", where}, 32'(exp_pen), 32'(payload_en_i))) begin
            payload_errors++;
        end
        if (!field_ok({"byte_data ", where}, 32'(exp_byte), 32'(byte_data_i))) byte_errors++;
        checks++;
    endtask

    // a new line opening closes the payload window of the previous one
    task automatic track_payload_run();
        logic line_open;
        line_open = pkt_i.sp && (pkt_i.dt != dsi_pkt_pkg::DT_HSYNC_END);
        if (line_open && header_seen) begin
            if (!field_ok("payload_run", 32'(dsi_timing_pkg::HACT), 32'(pen_run))) begin
                payload_errors++;
            end
            header_seen = 1'b0;
        end
        if (pkt_i.lp) begin
            header_seen = 1'b1;
            pen_run     = 0;
        end else if (payload_en_i) begin
            pen_run = pen_run + 1;
        end
    endtask

    //////////////////////////////////////////////////
    // raster model
    //////////////////////////////////////////////////

    task automatic predict_outputs();
        logic active_line;
        active_line = (line >= dsi_timing_pkg::VSA + dsi_timing_pkg::VBP) &&
                      (line < dsi_timing_pkg::VSA + dsi_timing_pkg::VBP + dsi_timing_pkg::VACT);
        exp_pkt         = '0;
        exp_pen         = 1'b0;
        exp_frame_start = 1'b0;
        exp_step        = enable_i;
        exp_col         = col;
        exp_line        = line;
        if (enable_i) begin
            if (col == '0) begin
                exp_pkt.sp = 1'b1;
                if (line == '0) begin
                    exp_pkt.dt      = dsi_pkt_pkg::DT_VSYNC_START;
                    exp_frame_start = 1'b1;
                end else if (line == dsi_timing_pkg::VSA) begin
                    exp_pkt.dt = dsi_pkt_pkg::DT_VSYNC_END;
                end else begin
                    exp_pkt.dt = dsi_pkt_pkg::DT_HSYNC_START;
                end
            end else if (col == dsi_timing_pkg::HSA && line != '0 &&
                         line != dsi_timing_pkg::VSA) begin
                exp_pkt.sp = 1'b1;
                exp_pkt.dt = dsi_pkt_pkg::DT_HSYNC_END;
            end
            if (active_line && col == dsi_timing_pkg::HSA + dsi_timing_pkg::HBP - 16'd1) begin
                exp_pkt.lp = 1'b1;
                exp_pkt.dt = dsi_pkt_pkg::DT_RGB888;
                exp_pkt.wc = dsi_pkt_pkg::ACTIVE_WC;
            end
            exp_pen = active_line && (col >= dsi_timing_pkg::HSA + dsi_timing_pkg::HBP) &&
                      (col < dsi_timing_pkg::HSA + dsi_timing_pkg::HBP + dsi_timing_pkg::HACT);
        end
    endtask

    task automatic advance_position();
        if (col == dsi_timing_pkg::H_TOTAL - 16'd1) begin
            col = '0;
            if (line == dsi_timing_pkg::V_TOTAL - 12'd1) begin
                line = '0;
            end else begin
                line = line + 12'd1;
            end
        end else begin
            col = col + 16'd1;
        end
    endtask

    // outputs are read before the DUT registers update on this edge
    always @(posedge clk) begin
        if (reset) begin
            col             = '0;
            line            = '0;
            exp_pkt         = '0;
            exp_pen         = 1'b0;
            exp_frame_start = 1'b0;
            exp_step        = 1'b0;
            lfsr            = dsi_pkt_pkg::PRBS_SEED;
            pen_run         = 0;
            header_seen     = 1'b0;
        end else begin
            compare_outputs();
            track_payload_run();
            if (exp_frame_start) begin
                frames = frames + 1;
                lfsr   = dsi_pkt_pkg::PRBS_SEED;
            end else if (exp_pen) begin
                lfsr = lfsr_step(lfsr);
            end
            predict_outputs();
            if (enable_i) begin
                advance_position();
            end
        end
    end

endmodule

// File: sim/tb_dsi_video_source.sv
// Testbench for the DSI video-mode source.
// Drives a random enable pattern on falling edges, lets the checker
// model every output and reports error counts after three frame starts.

`timescale 1ns/10ps

module tb_dsi_video_source;

    logic                  clk;
    logic                  reset;
    logic                  enable;
    dsi_pkt_pkg::pkt_hdr_t pkt;
    logic                  payload_en;
    dsi_pkt_pkg::byte_t    byte_data;

    int frames;
    int checks;
    int pkt_errors;
    int payload_errors;
    int byte_errors;
    int assert_errors;

    int seed;
    int cycles;
    int max_cycles;
    int total_errors;
    bit timed_out;

    initial begin
        clk = 1'b0;
    end

    // 100 ns period
    always #50 clk = ~clk;

    dsi_video_source dut (
        .clk          (clk),
        .reset        (reset),
        .enable_i     (enable),
        .pkt_o        (pkt),
        .payload_en_o (payload_en),
        .byte_data_o  (byte_data)
    );

    dsi_video_checker u_checker (
        .clk              (clk),
        .reset            (reset),
        .enable_i         (enable),
        .pkt_i            (pkt),
        .payload_en_i     (payload_en),
        .byte_data_i      (byte_data),
        .frames_o         (frames),
        .checks_o         (checks),
        .pkt_errors_o     (pkt_errors),
        .payload_errors_o (payload_errors),
        .byte_errors_o    (byte_errors)
    );

    bind packet_sequencer dsi_video_props u_props (
        .clk           (clk),
        .reset         (reset),
        .pkt_i         (pkt_o),
        .payload_en_i  (payload_en_o),
        .frame_start_i (frame_start_o)
    );

    //////////////////////////////////////////////////
    // stimulus and result
    //////////////////////////////////////////////////

    initial begin
        seed       = 6;
        max_cycles = 5000;
        cycles     = 0;
        timed_out  = 1'b0;
        reset      = 1'b1;
        enable     = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // about three clocks in four consume a position
        while (frames < 3 && !timed_out) begin
            enable = ($random(seed) % 4) != 0;
            @(negedge clk);
            cycles = cycles + 1;
            if (cycles >= max_cycles) begin
                timed_out = 1'b1;
            end
        end
        enable = 1'b0;
        // one more edge so the last prediction is compared
        @(negedge clk);
        assert_errors = dut.u_packet_sequencer.u_props.assert_errors;
        total_errors  = pkt_errors + payload_errors + byte_errors + assert_errors;
        if (timed_out) begin
            $display("timeout: only %0d of 3 frame starts seen in %0d cycles", frames, cycles);
        end
        $display("checks %0d frames %0d errors pkt %0d pen %0d byte %0d assert %0d total %0d",
                 checks, frames, pkt_errors, payload_errors, byte_errors, assert_errors,
                 total_errors);
        if (timed_out || total_errors != 0) begin
            $display("TEST RESULT: FAIL");
        end else begin
            $display("TEST RESULT: PASS");
        end
        $finish;
    end

endmodule

// File: build.f
design/dsi_timing_pkg.sv
design/dsi_pkt_pkg.sv
design/line_timer.sv
design/frame_timer.sv
design/packet_sequencer.sv
design/payload_prbs.sv
design/dsi_video_source.sv
sim/dsi_video_props.sv
sim/dsi_video_checker.sv
sim/tb_dsi_video_source.sv

// File: run_sim.sh
#!/bin/sh
# builds the DSI video source testbench with Verilator and runs it
rm -f build.log sim.log
verilator --binary --timing --assert -f build.f --top-module tb_dsi_video_source \
    -Mdir obj_dir -o tb_dsi_video_source > build.log 2>&1 \
    || { cat build.log; echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_dsi_video_source +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "no result line in sim.log"; exit 1; }
echo "simulation passed" && exit 0
